// File: source/seq_settings.svh
`ifndef SEQ_SETTINGS_SVH
`define SEQ_SETTINGS_SVH

// Status register layout
`define SEQ_DATA_W 8
`define SEQ_STATUS_C 0
`define SEQ_STATUS_Z 1
`define SEQ_STATUS_I 2
`define SEQ_STATUS_D 3
`define SEQ_STATUS_B 4
`define SEQ_STATUS_R 5
`define SEQ_STATUS_V 6
`define SEQ_STATUS_N 7

// Code widths of the instruction fields
`define SEQ_OPCODE_W 6
`define SEQ_MODE_W 4

`endif

// File: source/seq_pkg.sv
`include "seq_settings.svh"

package seq_pkg;

	typedef enum logic [`SEQ_OPCODE_W-1:0] {
		ADC, SBC, BIT, CMP, CPX, CPY,
		AND, ORA, EOR,
		ASL, LSR, ROL, ROR,
		INC, INX, INY, DEC, DEX, DEY,
		LDA, LDX, LDY, STA, STX, STY,
		SEC, SED, SEI, CLC, CLD, CLI, CLV,
		TAX, TAY, TSX, TXA, TXS, TYA,
		BCC, BCS, BNE, BEQ, BPL, BMI, BVC, BVS,
		JMP, NOP
	} opcode_e;

	typedef enum logic [`SEQ_MODE_W-1:0] {
		Imp, Imm, Zp, ZpX, ZpY, Abs, AbX, AbY, Rel
	} addr_mode_e;

	typedef enum logic [3:0] {
		ALU_TXA, ALU_TXB, ALU_ADD, ALU_SUB, ALU_AND,
		ALU_ORA, ALU_EOR, ALU_ROL, ALU_ROR, ALU_BIT
	} alu_func_e;

	typedef enum logic [2:0] {
		Fetch, Decode, ReadH, ReadHP, Execute, WriteBack, Branch, BranchOVF
	} step_e;

	typedef logic [`SEQ_DATA_W-1:0] status_t;

	typedef struct packed {
		logic branch_taken;
		logic is_jmp;
		logic is_rmw;
		logic is_store;
	} op_class_t;

	typedef struct packed {
		logic pc_addr_oe;
		logic ad_addr_oe;
	} addr_ctrl_t;

	typedef struct packed {
		logic inc;
		logic load;
	} pc_ctrl_t;

	// ALU A input, one select at a time
	typedef struct packed {
		logic con, acc, x, y, p, sp, dl, adl, adh, pcl, pch;
	} alu_bus_a_t;

	typedef struct packed {
		logic bus, con, dl;
	} alu_bus_b_t;

	// Result destinations
	typedef struct packed {
		logic bus, acc, x, y, p, sp, adl, adh, pcl, pch;
	} alu_bus_o_t;

	typedef struct packed {
		alu_func_e func;
		logic cinclr;
		alu_bus_a_t a;
		alu_bus_b_t b;
		alu_bus_o_t o;
	} alu_ctrl_t;

	typedef struct packed {
		status_t mask;	// Bits taken from the ALU flags
		status_t set;
		status_t clear;
	} p_ctrl_t;

endpackage

// File: source/opcode_decode.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module opcode_decode (
	input seq_pkg::opcode_e opcode_i,
	input seq_pkg::status_t p_i,
	output seq_pkg::op_class_t op_class_o
);
	import seq_pkg::*;

	always_comb begin
		op_class_o = '0;
		case (opcode_i)
		// Branch condition against the current flags
		BCC:	op_class_o.branch_taken = ~p_i[`SEQ_STATUS_C];
		BCS:	op_class_o.branch_taken = p_i[`SEQ_STATUS_C];
		BNE:	op_class_o.branch_taken = ~p_i[`SEQ_STATUS_Z];
		BEQ:	op_class_o.branch_taken = p_i[`SEQ_STATUS_Z];
		BPL:	op_class_o.branch_taken = ~p_i[`SEQ_STATUS_N];
		BMI:	op_class_o.branch_taken = p_i[`SEQ_STATUS_N];
		BVC:	op_class_o.branch_taken = ~p_i[`SEQ_STATUS_V];
		BVS:	op_class_o.branch_taken = p_i[`SEQ_STATUS_V];
		JMP:	op_class_o.is_jmp = 1'b1;
		ASL, LSR,
		ROL, ROR,
		INC, DEC:	op_class_o.is_rmw = 1'b1;	// Write-back in memory modes
		STA, STX,
		STY:	op_class_o.is_store = 1'b1;
		default:	;
		endcase
	end

endmodule

// File: source/cycle_sequencer.sv
`timescale 1ns/1ns

module cycle_sequencer (
	input logic rst_n_i,
	input logic sys,
	input logic bus_rdy_i,
	input seq_pkg::addr_mode_e mode_i,
	input seq_pkg::op_class_t op_class_i,
	input logic alu_cout_i,
	input logic dl_sign_i,
	output seq_pkg::addr_ctrl_t addr_o,
	output seq_pkg::pc_ctrl_t pc_o,
	output logic ins_we_o,
	output logic execute_o,
	output logic write_back_o,
	output seq_pkg::alu_ctrl_t route_alu_o
);
	import seq_pkg::*;

	step_e step;
	step_e step_next;
	logic cout_prev;	// ALU carry of the previous ready cycle

	always_ff @(posedge sys, negedge rst_n_i) begin
		if (!rst_n_i) begin
			step <= Fetch;
			cout_prev <= 1'b0;
		end else if (bus_rdy_i) begin
			step <= step_next;
			cout_prev <= alu_cout_i;
		end
	end

	always_comb begin
		step_next = step;
		addr_o = '0;
		pc_o = '0;
		ins_we_o = 1'b0;
		execute_o = 1'b0;
		write_back_o = 1'b0;
		route_alu_o = '0;
		route_alu_o.func = ALU_TXB;
		route_alu_o.a.con = 1'b1;
		route_alu_o.b.bus = 1'b1;
		case (step)
		Fetch:	begin
			addr_o.pc_addr_oe = 1'b1;
			pc_o.inc = 1'b1;
			ins_we_o = 1'b1;
			route_alu_o.func = ALU_TXA;	// Zero => ADH
			route_alu_o.o.adh = 1'b1;
			step_next = Decode;
		end
		Decode:	begin
			addr_o.pc_addr_oe = 1'b1;
			pc_o.inc = 1'b1;
			case (mode_i)
			Imp, Imm:	begin
				pc_o.inc = (mode_i == Imm);	// No operand byte for implied
				execute_o = 1'b1;
				step_next = Fetch;
			end
			Zp, Abs:	begin
				route_alu_o.o.adl = 1'b1;	// BUS => ADL
				step_next = (mode_i == Zp) ? Execute : ReadH;
			end
			ZpX, ZpY, AbX, AbY:	begin
				route_alu_o.func = ALU_ADD;	// Index + BUS => ADL
				route_alu_o.cinclr = 1'b1;
				route_alu_o.a.con = 1'b0;
				route_alu_o.a.x = (mode_i == ZpX) || (mode_i == AbX);
				route_alu_o.a.y = (mode_i == ZpY) || (mode_i == AbY);
				route_alu_o.o.adl = 1'b1;
				step_next = (mode_i inside {ZpX, ZpY}) ? Execute : ReadH;
			end
			Rel:	begin
				if (op_class_i.branch_taken) begin
					pc_o.inc = 1'b0;
					route_alu_o.func = ALU_ADD;	// PCL + offset => PCL
					route_alu_o.cinclr = 1'b1;
					route_alu_o.a.con = 1'b0;
					route_alu_o.a.pcl = 1'b1;
					route_alu_o.o.pcl = 1'b1;
					step_next = Branch;
				end else begin
					step_next = Fetch;
				end
			end
			default:	step_next = Fetch;
			endcase
		end
		ReadH:	begin
			addr_o.pc_addr_oe = 1'b1;
			route_alu_o.o.adh = 1'b1;	// BUS => ADH
			if (op_class_i.is_jmp) begin
				pc_o.load = 1'b1;
				step_next = Fetch;
			end else begin
				pc_o.inc = 1'b1;
				// Index add carried out of the low byte
				if ((mode_i inside {AbX, AbY}) && cout_prev)
					step_next = ReadHP;
				else
					step_next = Execute;
			end
		end
		ReadHP:	begin
			addr_o.ad_addr_oe = 1'b1;
			route_alu_o.func = ALU_ADD;	// ADH + 1 => ADH
			route_alu_o.cinclr = 1'b1;
			route_alu_o.a.con = 1'b0;
			route_alu_o.a.adh = 1'b1;
			route_alu_o.b.bus = 1'b0;
			route_alu_o.b.con = 1'b1;
			route_alu_o.o.adh = 1'b1;
			step_next = Execute;
		end
		Execute:	begin
			addr_o.ad_addr_oe = 1'b1;
			execute_o = ~op_class_i.is_rmw;	// RMW only reads here
			step_next = op_class_i.is_rmw ? WriteBack : Fetch;
		end
		WriteBack:	begin
			addr_o.ad_addr_oe = 1'b1;
			execute_o = 1'b1;
			write_back_o = 1'b1;
			step_next = Fetch;
		end
		Branch:	begin
			addr_o.pc_addr_oe = 1'b1;
			route_alu_o.func = dl_sign_i ? ALU_SUB : ALU_ADD;	// PCH +/- 1
			route_alu_o.cinclr = 1'b1;
			route_alu_o.a.con = 1'b0;
			route_alu_o.a.pch = 1'b1;
			route_alu_o.b.bus = 1'b0;
			route_alu_o.b.con = 1'b1;
			if (cout_prev ^ dl_sign_i) begin
				route_alu_o.o.pch = 1'b1;	// Target in another page
				step_next = BranchOVF;
			end else begin
				pc_o.inc = 1'b1;
				step_next = Fetch;
			end
		end
		BranchOVF:	begin
			addr_o.pc_addr_oe = 1'b1;
			pc_o.inc = 1'b1;
			step_next = Fetch;
		end
		default:	step_next = Fetch;
		endcase
	end

endmodule

// File: source/exec_ctrl.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module exec_ctrl (
	input logic execute_i,
	input logic write_back_i,
	input seq_pkg::opcode_e opcode_i,
	input seq_pkg::addr_mode_e mode_i,
	input seq_pkg::op_class_t op_class_i,
	input seq_pkg::alu_ctrl_t route_alu_i,
	output seq_pkg::alu_ctrl_t alu_o,
	output seq_pkg::p_ctrl_t p_o,
	output logic bus_we_o
);
	import seq_pkg::*;

	logic inc_dec;	// Uses the constant one on B
	logic on_acc;	// Shift or INC/DEC of the accumulator
	logic nz_upd;

	assign inc_dec = opcode_i inside {INC, INX, INY, DEC, DEX, DEY};
	assign on_acc = (mode_i == Imp);
	assign nz_upd = !(opcode_i inside {STA, STX, STY, JMP, NOP,
		SEC, SED, SEI, CLC, CLD, CLI, CLV,
		BCC, BCS, BNE, BEQ, BPL, BMI, BVC, BVS});

	always_comb begin
		alu_o = route_alu_i;
		p_o = '0;
		p_o.mask[`SEQ_STATUS_R] = 1'b1;
		bus_we_o = write_back_i;	// Modified byte back to memory
		if (execute_i) begin
			alu_o = '0;
			alu_o.b.bus = ~inc_dec;
			alu_o.b.con = inc_dec;
			alu_o.cinclr = inc_dec || (opcode_i inside {CMP, CPX, CPY, ASL, LSR});
			case (opcode_i)
			ADC, INC, INX, INY:	alu_o.func = ALU_ADD;
			SBC, CMP, CPX, CPY,
			DEC, DEX, DEY:	alu_o.func = ALU_SUB;
			BIT:	alu_o.func = ALU_BIT;
			AND:	alu_o.func = ALU_AND;
			ORA:	alu_o.func = ALU_ORA;
			EOR:	alu_o.func = ALU_EOR;
			ASL, ROL:	alu_o.func = ALU_ROL;	// ASL has carry-in cleared
			LSR, ROR:	alu_o.func = ALU_ROR;
			STA, STX, STY, TAX,
			TAY, TSX, TXA, TXS, TYA:	alu_o.func = ALU_TXA;
			default:	alu_o.func = ALU_TXB;	// Loads pass the bus
			endcase
			case (opcode_i)
			ADC, SBC, BIT, CMP, AND, ORA,
			EOR, STA, TAX, TAY:	alu_o.a.acc = 1'b1;
			CPX, INX, DEX, STX, TXA, TXS:	alu_o.a.x = 1'b1;
			CPY, INY, DEY, STY, TYA:	alu_o.a.y = 1'b1;
			TSX:	alu_o.a.sp = 1'b1;
			ASL, LSR, ROL, ROR, INC, DEC:	begin
				alu_o.a.acc = on_acc;
				alu_o.a.dl = ~on_acc;
			end
			default:	;
			endcase
			alu_o.a.con = (alu_o.a == '0);	// Constant when no register drives A
			case (opcode_i)
			ADC, SBC, AND, ORA, EOR, LDA, TXA, TYA:	alu_o.o.acc = 1'b1;
			LDX, TAX, TSX, INX, DEX:	alu_o.o.x = 1'b1;
			LDY, TAY, INY, DEY:	alu_o.o.y = 1'b1;
			TXS:	alu_o.o.sp = 1'b1;
			STA, STX, STY:	alu_o.o.bus = 1'b1;
			ASL, LSR, ROL, ROR, INC, DEC:	begin
				alu_o.o.acc = on_acc;
				alu_o.o.bus = ~on_acc;
			end
			default:	;
			endcase
			case (opcode_i)
			ADC, SBC:	begin
				p_o.mask[`SEQ_STATUS_C] = 1'b1;
				p_o.mask[`SEQ_STATUS_V] = 1'b1;
			end
			CMP, CPX, CPY,
			ASL, LSR, ROL, ROR:	p_o.mask[`SEQ_STATUS_C] = 1'b1;
			BIT:	p_o.mask[`SEQ_STATUS_V] = 1'b1;
			SEC:	p_o.set[`SEQ_STATUS_C] = 1'b1;
			SED:	p_o.set[`SEQ_STATUS_D] = 1'b1;
			SEI:	p_o.set[`SEQ_STATUS_I] = 1'b1;
			CLC:	p_o.clear[`SEQ_STATUS_C] = 1'b1;
			CLD:	p_o.clear[`SEQ_STATUS_D] = 1'b1;
			CLI:	p_o.clear[`SEQ_STATUS_I] = 1'b1;
			CLV:	p_o.clear[`SEQ_STATUS_V] = 1'b1;
			default:	;
			endcase
			p_o.mask[`SEQ_STATUS_N] = nz_upd;
			p_o.mask[`SEQ_STATUS_Z] = nz_upd;
			if (op_class_i.is_store)
				bus_we_o = 1'b1;
		end
	end

endmodule

// File: source/sequencer_top.sv
`timescale 1ns/1ns

module sequencer_top (
	input logic sys,
	input logic rst_n_i,
	input logic bus_rdy_i,
	input seq_pkg::opcode_e opcode_i,
	input seq_pkg::addr_mode_e mode_i,
	input seq_pkg::status_t p_i,
	input logic alu_cout_i,
	input logic dl_sign_i,
	output logic ins_we_o,
	output seq_pkg::addr_ctrl_t addr_o,
	output seq_pkg::pc_ctrl_t pc_o,
	output seq_pkg::alu_ctrl_t alu_o,
	output seq_pkg::p_ctrl_t p_o,
	output logic bus_we_o
);
	import seq_pkg::*;

	op_class_t op_class;
	alu_ctrl_t route_alu;	// Per-step address and PC routing
	logic execute;
	logic write_back;

	opcode_decode i_decode (
		.opcode_i(opcode_i),
		.p_i(p_i),
		.op_class_o(op_class)
	);

	cycle_sequencer i_seq (
		.rst_n_i(rst_n_i),
		.sys(sys),
		.bus_rdy_i(bus_rdy_i),
		.mode_i(mode_i),
		.op_class_i(op_class),
		.alu_cout_i(alu_cout_i),
		.dl_sign_i(dl_sign_i),
		.addr_o(addr_o),
		.pc_o(pc_o),
		.ins_we_o(ins_we_o),
		.execute_o(execute),
		.write_back_o(write_back),
		.route_alu_o(route_alu)
	);

	exec_ctrl i_exec (
		.execute_i(execute),
		.write_back_i(write_back),
		.opcode_i(opcode_i),
		.mode_i(mode_i),
		.op_class_i(op_class),
		.route_alu_i(route_alu),
		.alu_o(alu_o),
		.p_o(p_o),
		.bus_we_o(bus_we_o)
	);

endmodule

// File: bench/sequencer_props.sv
`timescale 1ns/1ns

module sequencer_props (
	input logic sys,
	input logic rst_n_i,
	input logic ins_we_i,
	input seq_pkg::addr_ctrl_t addr_i,
	input seq_pkg::pc_ctrl_t pc_i,
	input logic bus_we_i
);

	pc_exclusive: assert property (@(posedge sys) disable iff (!rst_n_i)
		!(pc_i.inc && pc_i.load))
		else $error("PC increment and load active together");

	fetch_from_pc: assert property (@(posedge sys) disable iff (!rst_n_i)
		ins_we_i |-> addr_i.pc_addr_oe)
		else $error("Instruction register written without the PC on the address bus");

	write_to_ad: assert property (@(posedge sys) disable iff (!rst_n_i)
		bus_we_i |-> addr_i.ad_addr_oe)	// Writes only go to the data address
		else $error("Bus write without the data address on the address bus");

endmodule

// File: bench/sequencer_tb.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module sequencer_tb;
	import seq_pkg::*;

	localparam int NUM_CYCLES = 3000;
	localparam int FETCH_TIMEOUT = 40;	// Longest instruction is 6 ready cycles

	logic sys;
	logic rst_n_i;
	logic bus_rdy_i;
	opcode_e opcode_i;
	addr_mode_e mode_i;
	status_t p_i;
	logic alu_cout_i;
	logic dl_sign_i;
	logic ins_we_o;
	addr_ctrl_t addr_o;
	pc_ctrl_t pc_o;
	alu_ctrl_t alu_o;
	p_ctrl_t p_o;
	logic bus_we_o;

	integer seed = 15;
	int errors = 0;
	int checks = 0;
	int instrs = 0;
	logic timed_out = 1'b0;

	// Model state
	int k = 0;	// Ready cycles since the fetch
	int exp_len = 0;
	int dut_len = 0;
	int since_fetch = 0;
	logic dec_carry = 1'b0;
	logic dec_taken = 1'b0;

	sequencer_top i_dut (.*);

	bind sequencer_top sequencer_props i_props (
		.sys(sys),
		.rst_n_i(rst_n_i),
		.ins_we_i(ins_we_o),
		.addr_i(addr_o),
		.pc_i(pc_o),
		.bus_we_i(bus_we_o)
	);

	always #20 sys = ~sys;

	// One bit per addr_mode_e code with Imp in bit 0
	function automatic logic [8:0] legal_modes(opcode_e op);
		case (op)
		ADC, SBC, AND, ORA, EOR, CMP, LDA:	return 9'b011101110;
		CPX, CPY:	return 9'b000100110;
		BIT:	return 9'b000100100;
		ASL, LSR, ROL, ROR:	return 9'b001101101;
		INC, DEC:	return 9'b001101100;
		LDX:	return 9'b010110110;
		LDY:	return 9'b001101110;
		STA:	return 9'b011101100;
		STX:	return 9'b000110100;
		STY:	return 9'b000101100;
		BCC, BCS, BNE, BEQ, BPL, BMI, BVC, BVS:	return 9'b100000000;
		JMP:	return 9'b000100000;
		default:	return 9'b000000001;
		endcase
	endfunction

	function automatic logic branch_cond(opcode_e op, status_t p);
		case (op)
		BCC:	return !p[`SEQ_STATUS_C];
		BCS:	return p[`SEQ_STATUS_C];
		BNE:	return !p[`SEQ_STATUS_Z];
		BEQ:	return p[`SEQ_STATUS_Z];
		BPL:	return !p[`SEQ_STATUS_N];
		BMI:	return p[`SEQ_STATUS_N];
		BVC:	return !p[`SEQ_STATUS_V];
		BVS:	return p[`SEQ_STATUS_V];
		default:	return 1'b0;
		endcase
	endfunction

	function automatic logic rmw_mem(opcode_e op, addr_mode_e mode);
		return (op inside {ASL, LSR, ROL, ROR, INC, DEC}) && (mode != Imp);
	endfunction

	function automatic int instr_length(opcode_e op, addr_mode_e mode, logic taken,
			logic carry, logic dsign);
		int rmw;
		rmw = rmw_mem(op, mode) ? 1 : 0;
		if (mode == Rel)
			return !taken ? 2 : ((carry != dsign) ? 4 : 3);	// Page fix-up on mismatch
		if (op == JMP)
			return 3;
		case (mode)
		Imp, Imm:	return 2;
		Zp, ZpX, ZpY:	return 3 + rmw;
		AbX, AbY:	return 4 + (carry ? 1 : 0) + rmw;
		default:	return 4 + rmw;
		endcase
	endfunction

	function automatic alu_func_e alu_op_for(opcode_e op);
		case (op)
		ADC, INC, INX, INY:	return ALU_ADD;
		SBC, CMP, CPX, CPY, DEC, DEX, DEY:	return ALU_SUB;
		BIT:	return ALU_BIT;
		AND:	return ALU_AND;
		ORA:	return ALU_ORA;
		EOR:	return ALU_EOR;
		ASL, ROL:	return ALU_ROL;
		LSR, ROR:	return ALU_ROR;
		STA, STX, STY, TAX, TAY, TSX, TXA, TXS, TYA:	return ALU_TXA;
		default:	return ALU_TXB;
		endcase
	endfunction

	function automatic p_ctrl_t flag_rule(opcode_e op);
		p_ctrl_t e;
		e = '0;
		e.mask[`SEQ_STATUS_R] = 1'b1;
		if (!(op inside {STA, STX, STY, NOP, SEC, SED, SEI, CLC, CLD, CLI, CLV})) begin
			e.mask[`SEQ_STATUS_N] = 1'b1;
			e.mask[`SEQ_STATUS_Z] = 1'b1;
		end
		if (op inside {ADC, SBC, CMP, CPX, CPY, ASL, LSR, ROL, ROR})
			e.mask[`SEQ_STATUS_C] = 1'b1;
		if (op inside {ADC, SBC, BIT})
			e.mask[`SEQ_STATUS_V] = 1'b1;
		case (op)
		SEC:	e.set[`SEQ_STATUS_C] = 1'b1;
		SED:	e.set[`SEQ_STATUS_D] = 1'b1;
		SEI:	e.set[`SEQ_STATUS_I] = 1'b1;
		CLC:	e.clear[`SEQ_STATUS_C] = 1'b1;
		CLD:	e.clear[`SEQ_STATUS_D] = 1'b1;
		CLI:	e.clear[`SEQ_STATUS_I] = 1'b1;
		CLV:	e.clear[`SEQ_STATUS_V] = 1'b1;
		default:	;
		endcase
		return e;
	endfunction

	task automatic alu_compare(string name, alu_ctrl_t exp, alu_ctrl_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic p_compare(string name, p_ctrl_t exp, p_ctrl_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic pc_compare(string name, pc_ctrl_t exp, pc_ctrl_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %b, got %b", name, exp, act);
		end
	endtask

	task automatic addr_compare(string name, addr_ctrl_t exp, addr_ctrl_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %b, got %b", name, exp, act);
		end
	endtask

	task automatic len_compare(string name, int exp, int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("[FAIL] %s: expected %0d cycles, got %0d", name, exp, act);
		end
	endtask

	task automatic bit_compare(string name, logic exp, logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s: expected %b, got %b", name, exp, act);
		end
	endtask

	// Checks the outputs of the current step and advances the model
	task automatic observe_cycle(output logic start);
		string tname;
		logic exec;
		alu_ctrl_t exp_alu;
		alu_ctrl_t act_view;
		p_ctrl_t exp_p;
		pc_ctrl_t exp_pc;
		addr_ctrl_t exp_addr;
		tname = $sformatf("%s/%s step %0d", opcode_i.name(), mode_i.name(), k);
		if (k == 1) begin
			dec_carry = alu_cout_i;
			dec_taken = branch_cond(opcode_i, p_i);
			exp_len = instr_length(opcode_i, mode_i, dec_taken, dec_carry, dl_sign_i);
		end else if (k == 2 && mode_i == Rel) begin
			exp_len = instr_length(opcode_i, mode_i, dec_taken, dec_carry, dl_sign_i);
		end
		exec = (k >= 1) && (k == exp_len - 1) && (mode_i != Rel) && (opcode_i != JMP);
		bit_compare({tname, " ins_we"}, k == 0, ins_we_o);
		bit_compare({tname, " bus_we"},
			exec && ((opcode_i inside {STA, STX, STY}) || rmw_mem(opcode_i, mode_i)), bus_we_o);
		if (k == 0) begin
			exp_alu = '0;
			exp_alu.func = ALU_TXA;	// Constant zero into ADH
			exp_alu.a.con = 1'b1;
			exp_alu.b.bus = 1'b1;
			exp_alu.o.adh = 1'b1;
			alu_compare({tname, " fetch alu"}, exp_alu, alu_o);
			exp_pc = '0;
			exp_pc.inc = 1'b1;
			pc_compare({tname, " fetch pc"}, exp_pc, pc_o);
			exp_addr = '0;
			exp_addr.pc_addr_oe = 1'b1;
			addr_compare({tname, " fetch addr"}, exp_addr, addr_o);
		end
		if (opcode_i == JMP && k == 2) begin
			exp_pc = '0;
			exp_pc.load = 1'b1;
			pc_compare({tname, " jump pc"}, exp_pc, pc_o);
		end
		if (exec) begin
			exp_alu = '0;
			exp_alu.func = alu_op_for(opcode_i);
			exp_alu.o.bus = (opcode_i inside {STA, STX, STY}) || rmw_mem(opcode_i, mode_i);
			act_view = '0;
			act_view.func = alu_o.func;
			act_view.o.bus = alu_o.o.bus;
			alu_compare({tname, " exec alu"}, exp_alu, act_view);
			p_compare({tname, " exec p"}, flag_rule(opcode_i), p_o);
			// Operand from the PC in Imp or Imm, from the data address otherwise
			exp_addr = '0;
			exp_addr.pc_addr_oe = (mode_i inside {Imp, Imm});
			exp_addr.ad_addr_oe = !(mode_i inside {Imp, Imm});
			addr_compare({tname, " exec addr"}, exp_addr, addr_o);
		end else begin
			exp_p = '0;
			exp_p.mask[`SEQ_STATUS_R] = 1'b1;
			p_compare({tname, " idle p"}, exp_p, p_o);
		end
		start = ins_we_o && bus_rdy_i;
		if (start) begin
			if (instrs > 0)
				len_compare($sformatf("%s/%s length", opcode_i.name(), mode_i.name()),
					exp_len, dut_len);
			instrs++;
			dut_len = 0;
			since_fetch = 0;
		end
		if (bus_rdy_i) begin
			dut_len++;
			if (k >= 1 && k == exp_len - 1)
				k = 0;
			else
				k++;
		end
		since_fetch++;
	endtask

	task automatic drive_inputs(input logic start);
		logic [31:0] r;
		logic [5:0] op_code;
		logic [3:0] m;
		logic [8:0] legal;
		opcode_e op;
		r = $random(seed);
		bus_rdy_i <= (r[1:0] != 2'b00);	// Ready 3 of 4 cycles
		p_i <= r[15:8];
		alu_cout_i <= r[16];
		dl_sign_i <= r[17];
		if (start) begin
			op_code = 6'($unsigned($random(seed)) % 48);
			op = opcode_e'(op_code);
			legal = legal_modes(op);
			do begin
				m = 4'($unsigned($random(seed)) % 9);
			end while (!legal[m]);
			opcode_i <= op;
			mode_i <= addr_mode_e'(m);
		end
	endtask

	initial begin
		int cyc;
		int wait_cnt;
		logic start;
		sys = 1'b0;
		rst_n_i = 1'b0;
		bus_rdy_i = 1'b1;
		opcode_i = NOP;
		mode_i = Imp;
		p_i = '0;
		alu_cout_i = 1'b0;
		dl_sign_i = 1'b0;
		repeat (3) @(posedge sys);
		rst_n_i <= 1'b1;
		@(negedge sys);
		wait_cnt = 0;
		while (!ins_we_o && wait_cnt < 10) begin
			@(negedge sys);
			wait_cnt++;
		end
		if (!ins_we_o) begin
			$display("Timeout: no fetch cycle after reset release");
			timed_out = 1'b1;
		end
		cyc = 0;
		while (!timed_out && cyc < NUM_CYCLES) begin
			observe_cycle(start);
			if (since_fetch > FETCH_TIMEOUT) begin
				$display("Timeout: no instruction fetch for %0d cycles", FETCH_TIMEOUT);
				timed_out = 1'b1;
			end else begin
				@(posedge sys);
				drive_inputs(start);
				@(negedge sys);
				cyc++;
			end
		end
		$display("Checks: %0d, errors: %0d, instructions: %0d", checks, errors, instrs);
		if (errors == 0 && !timed_out)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/seq_pkg.sv
source/opcode_decode.sv
source/cycle_sequencer.sv
source/exec_ctrl.sv
source/sequencer_top.sv
bench/sequencer_props.sv
bench/sequencer_tb.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f sources.f --top-module sequencer_tb -o sim_sequencer
./obj_dir/sim_sequencer | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1
